// ==== common/lcd_game_pkg.sv ====
package lcd_game_pkg;

  typedef logic [1:0]  height_t;    // 0 bottom row, 3 top row
  typedef logic [5:0]  scroll_t;    // display shift offset
  typedef logic [7:0]  lcd_byte_t;
  typedef logic [15:0] cycle_cnt_t; // long waits

  // wake-up and frame timing, in clock cycles
  localparam cycle_cnt_t POWER_ON_CYCLES = 16'd20000;
  localparam cycle_cnt_t WAKE_GAP_LONG   = 16'd2500;
  localparam cycle_cnt_t WAKE_GAP_SHORT  = 16'd80;
  localparam cycle_cnt_t FRAME_CYCLES    = 16'd4000;
  localparam int         E_HIGH_CYCLES   = 2;
  localparam int         SETTLE_CYCLES   = 19;

  localparam scroll_t   SCROLL_WIDTH  = 6'd40;
  localparam int        HISTORY_DEPTH = 12;
  localparam lcd_byte_t PLAYER_COL    = 8'd3;
  localparam lcd_byte_t PLATFORM_COL  = 8'd15;

  localparam int INIT_XFERS  = 13; // 3 wake + 6 config + 4 draw
  localparam int FRAME_XFERS = 13; // 4 erase pairs, shift, 2 draw pairs

  // line start address by height, entry 0 is the bottom line
  localparam logic [3:0][7:0] ROW_BASE = {8'h00, 8'h40, 8'h10, 8'h50};

  localparam lcd_byte_t CMD_WAKE       = 8'h30;
  localparam lcd_byte_t CMD_FUNCTION   = 8'h38;
  localparam lcd_byte_t CMD_CURSOR     = 8'h10;
  localparam lcd_byte_t CMD_DISPLAY_ON = 8'h0C;
  localparam lcd_byte_t CMD_ENTRY      = 8'h06;
  localparam lcd_byte_t CMD_CLEAR      = 8'h01;
  localparam lcd_byte_t CMD_HOME       = 8'h02;
  localparam lcd_byte_t CMD_SHIFT_LEFT = 8'h18;
  localparam lcd_byte_t CMD_SET_ADDR   = 8'h80;

  localparam lcd_byte_t CHAR_BLANK = 8'h20;
  localparam lcd_byte_t CHAR_BLOCK = 8'hFF;

endpackage

// ==== display/lcd_bus_driver.sv ====
`timescale 1ns/1ps

module lcd_bus_driver (
  input  logic                    clk,
  input  logic                    rst_l,
  input  logic                    xfer_req,
  input  logic                    xfer_rs,
  input  lcd_game_pkg::lcd_byte_t xfer_byte,
  output logic                    xfer_ack,
  output logic                    lcd_e,
  output logic                    lcd_rs,
  output lcd_game_pkg::lcd_byte_t lcd_data
);

  typedef enum logic [1:0] {
    B_IDLE,
    B_EHIGH,
    B_SETTLE,
    B_ACK
  } bus_state_t;

  bus_state_t state;
  logic [4:0] cnt;

  always_ff @(posedge clk or negedge rst_l)
  begin
    if (!rst_l)
    begin
      state    <= B_IDLE;
      cnt      <= '0;
      lcd_e    <= 1'b0;
      xfer_ack <= 1'b0;
    end
    else
    begin
      case (state)
        B_IDLE:
          if (xfer_req)
          begin
            cnt   <= '0;
            state <= B_EHIGH;
          end
        B_EHIGH:
          if (cnt == 5'(lcd_game_pkg::E_HIGH_CYCLES))
          begin
            lcd_e <= 1'b0;
            cnt   <= '0;
            state <= B_SETTLE;
          end
          else
          begin
            lcd_e <= 1'b1;
            cnt   <= cnt + 5'd1;
          end
        B_SETTLE:
          if (cnt == 5'(lcd_game_pkg::SETTLE_CYCLES - 1))
          begin
            xfer_ack <= 1'b1;
            state    <= B_ACK;
          end
          else
            cnt <= cnt + 5'd1;
        default:
          if (!xfer_req)
          begin
            xfer_ack <= 1'b0;
            state    <= B_IDLE;
          end
      endcase
    end
  end

  // pins set up one cycle ahead of lcd_e
  always_ff @(posedge clk)
  begin
    if (state == B_IDLE && xfer_req)
    begin
      lcd_rs   <= xfer_rs;
      lcd_data <= xfer_byte;
    end
  end

endmodule

// ==== display/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer (
  input  logic                    clk,
  input  logic                    rst_l,
  input  logic                    frame_req,
  input  lcd_game_pkg::scroll_t   scroll_old,
  input  lcd_game_pkg::scroll_t   scroll_new,
  input  lcd_game_pkg::height_t   pltfm_height,
  input  lcd_game_pkg::height_t   plyr_old,
  input  lcd_game_pkg::height_t   plyr_new,
  output logic                    frame_ack,
  output logic                    xfer_req,
  output logic                    xfer_rs,
  output lcd_game_pkg::lcd_byte_t xfer_byte,
  input  logic                    xfer_ack
);

  typedef enum logic [2:0] {
    W_POWER,
    W_SEND,
    W_RELEASE,
    W_GAP,      // wake-up spacing
    W_IDLE,
    W_DONE
  } wr_state_t;

  wr_state_t                state;
  lcd_game_pkg::cycle_cnt_t cnt;
  lcd_game_pkg::cycle_cnt_t gap_len;
  logic [3:0]               step;
  logic                     init_phase;

  // set-address command for a cell, wrapping inside the 7-bit address
  function automatic lcd_game_pkg::lcd_byte_t cell_addr(
    input lcd_game_pkg::height_t   h,
    input lcd_game_pkg::lcd_byte_t col,
    input lcd_game_pkg::scroll_t   sh
  );
    lcd_game_pkg::lcd_byte_t sum;
    sum = lcd_game_pkg::ROW_BASE[h] + col + {2'b00, sh};
    return lcd_game_pkg::CMD_SET_ADDR | {1'b0, sum[6:0]};
  endfunction

  assign gap_len   = (step == 4'd0) ? lcd_game_pkg::WAKE_GAP_LONG : lcd_game_pkg::WAKE_GAP_SHORT;

  always_comb
  begin
    xfer_rs   = 1'b0;
    xfer_byte = lcd_game_pkg::CMD_WAKE;
    if (init_phase)
    begin
      case (step)
        4'd3:  xfer_byte = lcd_game_pkg::CMD_FUNCTION;
        4'd4:  xfer_byte = lcd_game_pkg::CMD_CURSOR;
        4'd5:  xfer_byte = lcd_game_pkg::CMD_DISPLAY_ON;
        4'd6:  xfer_byte = lcd_game_pkg::CMD_ENTRY;
        4'd7:  xfer_byte = lcd_game_pkg::CMD_CLEAR;
        4'd8:  xfer_byte = lcd_game_pkg::CMD_HOME;
        4'd9:  xfer_byte = cell_addr(pltfm_height, lcd_game_pkg::PLATFORM_COL, 6'd0);
        4'd11: xfer_byte = cell_addr(plyr_new, lcd_game_pkg::PLAYER_COL, 6'd0);
        4'd10, 4'd12:
        begin
          xfer_rs   = 1'b1;
          xfer_byte = lcd_game_pkg::CHAR_BLOCK;
        end
        default: xfer_byte = lcd_game_pkg::CMD_WAKE; // steps 0 to 2
      endcase
    end
    else
    begin
      case (step)
        4'd0:  xfer_byte = cell_addr(2'd2, 8'd0, scroll_old); // column leaving the screen
        4'd2:  xfer_byte = cell_addr(2'd1, 8'd0, scroll_old);
        4'd4:  xfer_byte = cell_addr(2'd0, 8'd0, scroll_old);
        4'd6:  xfer_byte = cell_addr(plyr_old, lcd_game_pkg::PLAYER_COL, scroll_old);
        4'd8:  xfer_byte = lcd_game_pkg::CMD_SHIFT_LEFT;
        4'd9:  xfer_byte = cell_addr(pltfm_height, lcd_game_pkg::PLATFORM_COL, scroll_new);
        4'd11: xfer_byte = cell_addr(plyr_new, lcd_game_pkg::PLAYER_COL, scroll_new);
        4'd10, 4'd12:
        begin
          xfer_rs   = 1'b1;
          xfer_byte = lcd_game_pkg::CHAR_BLOCK;
        end
        default:
        begin
          xfer_rs   = 1'b1; // odd erase steps
          xfer_byte = lcd_game_pkg::CHAR_BLANK;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_l)
  begin
    if (!rst_l)
    begin
      state      <= W_POWER;
      cnt        <= '0;
      step       <= '0;
      init_phase <= 1'b1;
      xfer_req   <= 1'b0;
      frame_ack  <= 1'b0;
    end
    else
    begin
      case (state)
        W_POWER:
        begin
          frame_ack <= 1'b1; // holds engine off during init
          if (cnt == lcd_game_pkg::POWER_ON_CYCLES - 16'd1)
          begin
            xfer_req <= 1'b1;
            state    <= W_SEND;
          end
          else
            cnt <= cnt + 16'd1;
        end
        W_SEND:
          if (xfer_ack)
          begin
            xfer_req <= 1'b0;
            state    <= W_RELEASE;
          end
        W_RELEASE:
          if (!xfer_ack)
          begin
            if (step == 4'(lcd_game_pkg::FRAME_XFERS - 1)) // last of init or frame
            begin
              step       <= '0;
              init_phase <= 1'b0;
              frame_ack  <= !init_phase;
              state      <= init_phase ? W_IDLE : W_DONE;
            end
            else if (init_phase && step < 4'd3)
            begin
              cnt   <= '0;
              state <= W_GAP;
            end
            else
            begin
              step     <= step + 4'd1;
              xfer_req <= 1'b1;
              state    <= W_SEND;
            end
          end
        W_GAP:
          if (cnt == gap_len - 16'd1)
          begin
            step     <= step + 4'd1;
            xfer_req <= 1'b1;
            state    <= W_SEND;
          end
          else
            cnt <= cnt + 16'd1;
        W_IDLE:
          if (frame_req)
          begin
            xfer_req <= 1'b1;
            state    <= W_SEND;
          end
        default:
          if (!frame_req)
          begin
            frame_ack <= 1'b0;
            state     <= W_IDLE;
          end
      endcase
    end
  end

endmodule

// ==== game/game_engine.sv ====
`timescale 1ns/1ps

module game_engine (
  input  logic                  clk,
  input  logic                  rst_l,
  input  logic                  jump,
  input  logic                  frame_ack,
  output logic                  frame_req,
  output lcd_game_pkg::scroll_t scroll_old,
  output lcd_game_pkg::scroll_t scroll_new,
  output lcd_game_pkg::height_t pltfm_height,
  output lcd_game_pkg::height_t plyr_old,
  output lcd_game_pkg::height_t plyr_new,
  output logic                  crash,
  output logic                  game_over
);

  typedef enum logic [2:0] {
    E_BOOT,     // writer still in init
    E_RELEASE,
    E_COUNT,
    E_REQ,
    E_OVER
  } eng_state_t;

  eng_state_t                 state;
  lcd_game_pkg::cycle_cnt_t   cnt;
  logic                       jump_q;
  lcd_game_pkg::height_t [lcd_game_pkg::HISTORY_DEPTH-1:0] hist;

  lcd_game_pkg::height_t under;
  lcd_game_pkg::height_t pltfm_next;
  lcd_game_pkg::height_t plyr_next;
  lcd_game_pkg::scroll_t scroll_next;
  logic                  jmp;
  logic                  crash_next;
  logic                  update;

  assign update = (state == E_COUNT) && (cnt == lcd_game_pkg::FRAME_CYCLES - 16'd1);
  assign under  = hist[lcd_game_pkg::HISTORY_DEPTH-1]; // platform below the player
  assign jmp    = jump_q | jump;

  always_comb
  begin
    scroll_next = (scroll_new == lcd_game_pkg::SCROLL_WIDTH - 6'd1) ? 6'd0 : scroll_new + 6'd1;

    pltfm_next = pltfm_height;
    if (pltfm_height == under)
      pltfm_next = (pltfm_height == 2'd2) ? 2'd0 : pltfm_height + 2'd1;

    plyr_next = plyr_new;
    if (jmp)
    begin
      if (plyr_new != 2'd3)
        plyr_next = plyr_new + 2'd1;
    end
    else if ({1'b0, plyr_new} > ({1'b0, under} + 3'd1))
      plyr_next = plyr_new - 2'd1;

    crash_next = (plyr_next <= under);
  end

  always_ff @(posedge clk or negedge rst_l)
  begin
    if (!rst_l)
    begin
      state        <= E_BOOT;
      cnt          <= '0;
      jump_q       <= 1'b0;
      hist         <= '0;
      frame_req    <= 1'b0;
      scroll_old   <= '0;
      scroll_new   <= '0;
      pltfm_height <= 2'd0;
      plyr_old     <= 2'd1;
      plyr_new     <= 2'd1;
      crash        <= 1'b0;
      game_over    <= 1'b0;
    end
    else
    begin
      jump_q <= update ? 1'b0 : jmp;
      case (state)
        E_BOOT:
          if (frame_ack)
            state <= E_RELEASE;
        E_RELEASE:
          if (!frame_ack)
          begin
            cnt <= '0;
            if (crash)
            begin
              game_over <= 1'b1; // frozen from here on
              state     <= E_OVER;
            end
            else
              state <= E_COUNT;
          end
        E_COUNT:
          if (update)
          begin
            scroll_old   <= scroll_new;
            scroll_new   <= scroll_next;
            pltfm_height <= pltfm_next;
            hist         <= {hist[lcd_game_pkg::HISTORY_DEPTH-2:0], pltfm_next};
            plyr_old     <= plyr_new;
            plyr_new     <= plyr_next;
            crash        <= crash_next;
            frame_req    <= 1'b1;
            state        <= E_REQ;
          end
          else
            cnt <= cnt + 16'd1;
        E_REQ:
          if (frame_ack)
          begin
            frame_req <= 1'b0;
            state     <= E_RELEASE;
          end
        default: ; // E_OVER holds
      endcase
    end
  end

endmodule

// ==== src/lcd_game_top.sv ====
`timescale 1ns/1ps

module lcd_game_top (
  input  logic                   clk,
  input  logic                   rst_l,
  input  logic                   jump,
  output logic                   lcd_e,
  output logic                   lcd_rs,
  output lcd_game_pkg::lcd_byte_t lcd_data,
  output logic                   game_over
);

  logic                    frame_req;
  logic                    frame_ack;
  lcd_game_pkg::scroll_t   scroll_old;
  lcd_game_pkg::scroll_t   scroll_new;
  lcd_game_pkg::height_t   pltfm_height;
  lcd_game_pkg::height_t   plyr_old;
  lcd_game_pkg::height_t   plyr_new;
  logic                    crash;     // visible for debug
  logic                    xfer_req;
  logic                    xfer_ack;
  logic                    xfer_rs;
  lcd_game_pkg::lcd_byte_t xfer_byte;

  game_engine u_game_engine (
    .clk          (clk),
    .rst_l        (rst_l),
    .jump         (jump),
    .frame_ack    (frame_ack),
    .frame_req    (frame_req),
    .scroll_old   (scroll_old),
    .scroll_new   (scroll_new),
    .pltfm_height (pltfm_height),
    .plyr_old     (plyr_old),
    .plyr_new     (plyr_new),
    .crash        (crash),
    .game_over    (game_over)
  );

  frame_writer u_frame_writer (
    .clk          (clk),
    .rst_l        (rst_l),
    .frame_req    (frame_req),
    .scroll_old   (scroll_old),
    .scroll_new   (scroll_new),
    .pltfm_height (pltfm_height),
    .plyr_old     (plyr_old),
    .plyr_new     (plyr_new),
    .frame_ack    (frame_ack),
    .xfer_req     (xfer_req),
    .xfer_rs      (xfer_rs),
    .xfer_byte    (xfer_byte),
    .xfer_ack     (xfer_ack)
  );

  lcd_bus_driver u_lcd_bus_driver (
    .clk       (clk),
    .rst_l     (rst_l),
    .xfer_req  (xfer_req),
    .xfer_rs   (xfer_rs),
    .xfer_byte (xfer_byte),
    .xfer_ack  (xfer_ack),
    .lcd_e     (lcd_e),
    .lcd_rs    (lcd_rs),
    .lcd_data  (lcd_data)
  );

endmodule

// ==== tb/lcd_game_props.sv ====
`timescale 1ns/1ps

module lcd_game_props (
  input logic                    clk,
  input logic                    rst_l,
  input logic                    xfer_req,
  input logic                    xfer_ack,
  input logic                    lcd_e,
  input logic                    lcd_rs,
  input lcd_game_pkg::lcd_byte_t lcd_data
);

  int fail_cnt = 0; // read by the testbench at the end

  ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_l) $rose(xfer_ack) |-> xfer_req
  )
  else
  begin
    fail_cnt++;
    $error("xfer_ack rose while xfer_req was low");
  end

  pins_hold: assert property (
    @(posedge clk) disable iff (!rst_l) lcd_e |-> $stable(lcd_rs) && $stable(lcd_data)
  )
  else
  begin
    fail_cnt++;
    $error("lcd_rs or lcd_data moved while lcd_e was high");
  end

  // enable pulse width
  e_width: assert property (
    @(posedge clk) disable iff (!rst_l)
      $rose(lcd_e) |-> lcd_e [*lcd_game_pkg::E_HIGH_CYCLES] ##1 !lcd_e
  )
  else
  begin
    fail_cnt++;
    $error("lcd_e high time differs from the enable pulse width");
  end

endmodule

bind lcd_bus_driver lcd_game_props u_lcd_game_props (
  .clk      (clk),
  .rst_l    (rst_l),
  .xfer_req (xfer_req),
  .xfer_ack (xfer_ack),
  .lcd_e    (lcd_e),
  .lcd_rs   (lcd_rs),
  .lcd_data (lcd_data)
);

// ==== tb/lcd_game_tb.sv ====
`timescale 1ns/1ps

module lcd_game_tb;

  localparam int XFER_CYCLES   = 30; // upper bound for one transfer
  localparam int HIST          = lcd_game_pkg::HISTORY_DEPTH;
  localparam int FRAME_GAP     = lcd_game_pkg::FRAME_CYCLES;
  localparam int XFER_WAIT     = lcd_game_pkg::POWER_ON_CYCLES + 1000;
  localparam int SURVIVE_FRAMES = 44; // random jumps up to here, then the player drops
  localparam int MAX_FRAMES    = 60;
  localparam int INIT_LEN      = lcd_game_pkg::POWER_ON_CYCLES + lcd_game_pkg::WAKE_GAP_LONG
                                 + 2 * lcd_game_pkg::WAKE_GAP_SHORT
                                 + lcd_game_pkg::INIT_XFERS * XFER_CYCLES;
  localparam int FRAME_LEN     = FRAME_GAP + lcd_game_pkg::FRAME_XFERS * XFER_CYCLES;
  localparam int TIMEOUT_CYCLES = (2 * INIT_LEN + (MAX_FRAMES + 2) * FRAME_LEN) * 6 / 5;

  logic                    clk = 1'b0;
  logic                    rst_l;
  logic                    jump;
  logic                    lcd_e;
  logic                    lcd_rs;
  lcd_game_pkg::lcd_byte_t lcd_data;
  logic                    game_over;

  integer     seed;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         cycles = 0;
  bit         aborted = 1'b0;
  bit         pending_jump;
  bit         crashed;
  int         frame;
  logic [8:0] got_q[$]; // {rs, byte}
  logic [8:0] exp_q[$];

  // reference game state
  int         ref_scroll;
  logic [1:0] ref_pltfm;
  logic [1:0] ref_plyr;
  logic [1:0] ref_hist [HIST]; // last entry is the oldest

  lcd_game_top u_lcd_game_top (
    .clk       (clk),
    .rst_l     (rst_l),
    .jump      (jump),
    .lcd_e     (lcd_e),
    .lcd_rs    (lcd_rs),
    .lcd_data  (lcd_data),
    .game_over (game_over)
  );

  always #2 clk = ~clk;

  always @(negedge lcd_e)
    if (rst_l === 1'b1)
      got_q.push_back({lcd_rs, lcd_data});

  always @(posedge clk)
  begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [7:0] row_base(input logic [1:0] h);
    case (h)
      2'd0: return 8'h50;
      2'd1: return 8'h10;
      2'd2: return 8'h40;
      default: return 8'h00;
    endcase
  endfunction

  function automatic logic [7:0] cell_cmd(input logic [1:0] h, input int col, input int sh);
    int a;
    a = row_base(h) + col + sh;
    return lcd_game_pkg::CMD_SET_ADDR | 8'(a % 128);
  endfunction

  function automatic logic [1:0] player_next(input logic [1:0] plyr, input logic [1:0] under,
                                             input logic jmp);
    if (jmp)
      return (plyr == 2'd3) ? 2'd3 : plyr + 2'd1;
    if (int'(plyr) > int'(under) + 1)
      return plyr - 2'd1;
    return plyr;
  endfunction

  function automatic void push_xfer(input logic rs, input logic [7:0] b);
    exp_q.push_back({rs, b});
  endfunction

  function automatic void reset_model();
    ref_scroll = 0;
    ref_pltfm  = 2'd0;
    ref_plyr   = 2'd1;
    for (int i = 0; i < HIST; i++)
      ref_hist[i] = 2'd0;
    pending_jump = 1'b0;
    exp_q.delete();
  endfunction

  // one game update, queues the frame's transfers, returns the crash flag
  function automatic logic ref_frame(input logic jmp);
    logic [1:0] under;
    logic [1:0] p_next;
    logic [1:0] pl_next;
    int         s_new;
    under   = ref_hist[HIST-1];
    s_new   = (ref_scroll + 1) % 40;
    p_next  = (ref_pltfm == under) ? 2'((ref_pltfm + 1) % 3) : ref_pltfm;
    pl_next = player_next(ref_plyr, under, jmp);
    for (int i = HIST - 1; i > 0; i--)
      ref_hist[i] = ref_hist[i-1];
    ref_hist[0] = p_next;
    for (int h = 2; h >= 0; h--)
    begin
      push_xfer(1'b0, cell_cmd(2'(h), 0, ref_scroll)); // column scrolling away
      push_xfer(1'b1, lcd_game_pkg::CHAR_BLANK);
    end
    push_xfer(1'b0, cell_cmd(ref_plyr, lcd_game_pkg::PLAYER_COL, ref_scroll));
    push_xfer(1'b1, lcd_game_pkg::CHAR_BLANK);
    push_xfer(1'b0, lcd_game_pkg::CMD_SHIFT_LEFT);
    push_xfer(1'b0, cell_cmd(p_next, lcd_game_pkg::PLATFORM_COL, s_new));
    push_xfer(1'b1, lcd_game_pkg::CHAR_BLOCK);
    push_xfer(1'b0, cell_cmd(pl_next, lcd_game_pkg::PLAYER_COL, s_new));
    push_xfer(1'b1, lcd_game_pkg::CHAR_BLOCK);
    ref_scroll = s_new;
    ref_pltfm  = p_next;
    ref_plyr   = pl_next;
    return pl_next <= under;
  endfunction

  task automatic get_xfer(output logic [8:0] v);
    int waited;
    waited = 0;
    v = '0;
    while (got_q.size() == 0 && !aborted)
    begin
      @(negedge clk);
      waited++;
      if (waited > XFER_WAIT)
      begin
        $display("error: no LCD transfer arrived within %0d cycles", XFER_WAIT);
        errors++;
        aborted = 1'b1;
      end
    end
    if (!aborted)
      v = got_q.pop_front();
  endtask

  task automatic check_xfers(input string name);
    logic [8:0] exp_v;
    logic [8:0] got_v;
    int         idx;
    idx = 0;
    while (exp_q.size() > 0 && !aborted)
    begin
      exp_v = exp_q.pop_front();
      get_xfer(got_v);
      if (!aborted && got_v !== exp_v)
      begin
        $display("MISMATCH %s xfer %0d: expected rs=%0b byte=0x%02h, actual rs=%0b byte=0x%02h",
                 name, idx, exp_v[8], exp_v[7:0], got_v[8], got_v[7:0]);
        errors++;
      end
      idx++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    tests_run++;
    if (errors == start)
      $display("test %-18s ok", name);
    else
    begin
      tests_failed++;
      $display("test %-18s FAILED with %0d errors", name, errors - start);
    end
  endtask

  task automatic decide_jump(input int k);
    logic [1:0]  under;
    logic        forced;
    logic [31:0] r;
    under  = ref_hist[HIST-1];
    forced = (player_next(ref_plyr, under, 1'b0) <= under); // keeps the game alive early on
    r      = $random(seed);
    pending_jump = (k < SURVIVE_FRAMES) && (r[0] || forced);
    if (pending_jump)
    begin
      @(negedge clk);
      jump = 1'b1;
      @(negedge clk);
      jump = 1'b0;
    end
  endtask

  task automatic start_game(input string tag);
    int start;
    reset_model();
    start = errors;
    repeat (3) push_xfer(1'b0, lcd_game_pkg::CMD_WAKE);
    push_xfer(1'b0, lcd_game_pkg::CMD_FUNCTION);
    push_xfer(1'b0, lcd_game_pkg::CMD_CURSOR);
    push_xfer(1'b0, lcd_game_pkg::CMD_DISPLAY_ON);
    push_xfer(1'b0, lcd_game_pkg::CMD_ENTRY);
    push_xfer(1'b0, lcd_game_pkg::CMD_CLEAR);
    push_xfer(1'b0, lcd_game_pkg::CMD_HOME);
    check_xfers({tag, "_init"});
    report_test({tag, "_init"}, start);
    start = errors;
    push_xfer(1'b0, cell_cmd(ref_pltfm, lcd_game_pkg::PLATFORM_COL, 0));
    push_xfer(1'b1, lcd_game_pkg::CHAR_BLOCK);
    push_xfer(1'b0, cell_cmd(ref_plyr, lcd_game_pkg::PLAYER_COL, 0));
    push_xfer(1'b1, lcd_game_pkg::CHAR_BLOCK);
    check_xfers({tag, "_draw"});
    report_test({tag, "_draw"}, start);
    decide_jump(0);
  endtask

  task automatic play_frame(input string tag, input int k, output bit crash);
    string name;
    int    start;
    name  = $sformatf("%s_frame_%0d", tag, k);
    start = errors;
    crash = ref_frame(pending_jump);
    check_xfers(name);
    if (!aborted && game_over !== 1'b0)
    begin
      $display("MISMATCH %s game_over: expected 0, actual %b", name, game_over);
      errors++;
    end
    report_test(name, start);
    if (!crash)
      decide_jump(k);
  endtask

  task automatic reset_mid_game();
    int start;
    int waited;
    start  = errors;
    waited = 0;
    while (lcd_e !== 1'b1 && waited < XFER_WAIT && !aborted)
    begin
      @(negedge clk);
      waited++;
    end
    if (lcd_e !== 1'b1)
    begin
      $display("error: no frame started before the mid-game reset");
      errors++;
    end
    rst_l = 1'b0; // in the middle of an enable pulse
    @(negedge clk);
    if (lcd_e !== 1'b0)
    begin
      $display("MISMATCH reset_mid_game lcd_e: expected 0, actual %b", lcd_e);
      errors++;
    end
    repeat (9) @(negedge clk);
    got_q.delete();
    rst_l = 1'b1;
    report_test("reset_mid_game", start);
  endtask

  task automatic check_game_over(input int k);
    int start;
    int waited;
    bit saw_e;
    bit dropped;
    start   = errors;
    waited  = 0;
    saw_e   = 1'b0;
    dropped = 1'b0;
    while (game_over !== 1'b1 && waited < 200)
    begin
      @(negedge clk);
      waited++;
    end
    if (game_over !== 1'b1)
    begin
      $display("error: game_over did not rise after crash frame %0d", k);
      errors++;
    end
    else
    begin
      repeat (2 * FRAME_GAP)
      begin
        @(negedge clk);
        if (lcd_e !== 1'b0)
          saw_e = 1'b1;
        if (game_over !== 1'b1)
          dropped = 1'b1;
      end
      if (saw_e || got_q.size() > 0)
      begin
        $display("error: the LCD was still written after game over");
        errors++;
      end
      if (dropped)
      begin
        $display("error: game_over fell again after the crash");
        errors++;
      end
    end
    report_test("game_over", start);
  endtask

  // game_over is high here, so reset has to pull it down
  task automatic reset_after_crash();
    int start;
    start = errors;
    rst_l = 1'b0;
    @(negedge clk);
    if (game_over !== 1'b0)
    begin
      $display("MISMATCH reset_after_crash game_over: expected 0, actual %b", game_over);
      errors++;
    end
    rst_l = 1'b1;
    report_test("reset_after_crash", start);
  endtask

  task automatic finish_run();
    int bus_fails;
    bus_fails = u_lcd_game_top.u_lcd_bus_driver.u_lcd_game_props.fail_cnt;
    errors    = errors + bus_fails;
    $display("tests %0d, failed %0d, errors %0d, bus assertion failures %0d",
             tests_run, tests_failed, errors, bus_fails);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  endtask

  initial
  begin
    seed  = 32'h95b6_470a;
    jump  = 1'b0;
    rst_l = 1'b0;
    repeat (10) @(negedge clk);
    rst_l = 1'b1;
    start_game("game1");
    for (int f = 1; f <= 4; f++)
      play_frame("game1", f, crashed);
    reset_mid_game();
    start_game("game2");
    frame   = 0;
    crashed = 1'b0;
    while (!crashed && !aborted && frame < MAX_FRAMES)
    begin
      frame++;
      play_frame("game2", frame, crashed);
    end
    if (!crashed && !aborted)
    begin
      $display("error: the reference game reached no crash within %0d frames", MAX_FRAMES);
      errors++;
    end
    if (!aborted)
    begin
      check_game_over(frame);
      reset_after_crash();
    end
    finish_run();
  end

endmodule

// ==== project.f ====
common/lcd_game_pkg.sv
display/lcd_bus_driver.sv
display/frame_writer.sv
game/game_engine.sv
src/lcd_game_top.sv
tb/lcd_game_props.sv
tb/lcd_game_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_game

sources:
  - files:
      - common/lcd_game_pkg.sv
      - display/lcd_bus_driver.sv
      - display/frame_writer.sv
      - game/game_engine.sv
      - src/lcd_game_top.sv
  - target: test
    files:
      - tb/lcd_game_props.sv
      - tb/lcd_game_tb.sv
